/* verilog/mulDiv_macros.svh */
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// Operand and result width
`define MD_DATA_WIDTH 32

// Age tag width
`define MD_TAG_WIDTH 4

// Register stages behind the multiplier array
`define MD_MUL_STAGES 3

// Writeback credits held after reset
`define MD_RESULT_CREDITS 4

`endif

/* verilog/mulDivPkg.sv */
`include "mulDiv_macros.svh"

package mulDivPkg;

    // Operand signedness for multiplication
    typedef enum logic [1:0] {
        MUL_SS = 2'b00,
        MUL_SU = 2'b01,
        MUL_UU = 2'b10
    } mulCode_e;

    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } divCode_e;

    // One opcode word, read through the view that isDiv selects
    typedef union packed {
        struct packed {
            mulCode_e code;
            logic     getUpper;
        } mul;
        struct packed {
            divCode_e code;
            logic     spare;
        } div;
    } mulDivOp_u;

    // Circular range from head up to but not including tail
    function automatic logic tagInFlushRange(
        input logic                     flushAll,
        input logic [`MD_TAG_WIDTH-1:0] head,
        input logic [`MD_TAG_WIDTH-1:0] tail,
        input logic [`MD_TAG_WIDTH-1:0] tag
    );
        logic hit;
        if (flushAll) begin
            hit = 1'b1;
        end else if (head <= tail) begin
            hit = (tag >= head) && (tag < tail);
        end else begin
            // Range wraps past the top of the tag space
            hit = (tag >= head) || (tag < tail);
        end
        return hit;
    endfunction

endpackage

/* verilog/pipelinedMultiplier.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module pipelinedMultiplier (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      mulValid,
    input  mulDivPkg::mulDivOp_u      op,
    input  logic [`MD_DATA_WIDTH-1:0] opA,
    input  logic [`MD_DATA_WIDTH-1:0] opB,
    input  logic [`MD_TAG_WIDTH-1:0]  tag,
    input  logic                      mulTaken,
    input  logic                      flushValid,
    input  logic                      flushAll,
    input  logic [`MD_TAG_WIDTH-1:0]  flushHead,
    input  logic [`MD_TAG_WIDTH-1:0]  flushTail,
    output logic                      mulReady,
    output logic                      mulOutValid,
    output logic [`MD_DATA_WIDTH-1:0] mulOutData,
    output logic [`MD_TAG_WIDTH-1:0]  mulOutTag
);

    localparam int W = `MD_DATA_WIDTH;
    localparam int STAGES = `MD_MUL_STAGES;

    logic                     signA;
    logic                     signB;
    logic signed [W:0]        extA;
    logic signed [W:0]        extB;
    logic signed [2*W+1:0]    fullProduct;

    logic [2*W-1:0]           prodQ [STAGES];
    logic [`MD_TAG_WIDTH-1:0] tagQ  [STAGES];
    logic [STAGES-1:0]        upperQ;
    logic [STAGES-1:0]        validQ;
    logic [STAGES-1:0]        flushHit;
    logic                     stall;

    // One extra bit per operand covers all three signedness codes
    always_comb begin
        signA = (op.mul.code != mulDivPkg::MUL_UU) && opA[W-1];
        signB = (op.mul.code == mulDivPkg::MUL_SS) && opB[W-1];
        extA = {signA, opA};
        extB = {signB, opB};
        fullProduct = extA * extB;
    end

    always_comb begin
        for (int i = 0; i < STAGES; i++) begin
            flushHit[i] = flushValid && validQ[i] &&
                mulDivPkg::tagInFlushRange(flushAll, flushHead, flushTail, tagQ[i]);
        end
    end

    // Whole pipe freezes while the last stage waits for the merger
    assign mulOutValid = validQ[STAGES-1] && !flushHit[STAGES-1];
    assign stall = mulOutValid && !mulTaken;
    assign mulReady = !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= '0;
        end else if (stall) begin
            validQ <= validQ & ~flushHit;
        end else begin
            validQ[0] <= mulValid;
            for (int i = 1; i < STAGES; i++) begin
                validQ[i] <= validQ[i-1] && !flushHit[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            prodQ[0] <= fullProduct[2*W-1:0];
            tagQ[0] <= tag;
            upperQ[0] <= op.mul.getUpper;
            for (int i = 1; i < STAGES; i++) begin
                prodQ[i] <= prodQ[i-1];
                tagQ[i] <= tagQ[i-1];
                upperQ[i] <= upperQ[i-1];
            end
        end
    end

    // High or low half picked at the output
    assign mulOutData = upperQ[STAGES-1] ? prodQ[STAGES-1][2*W-1:W] : prodQ[STAGES-1][W-1:0];
    assign mulOutTag = tagQ[STAGES-1];

endmodule

/* verilog/iterativeDivider.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module iterativeDivider (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      divReq,
    input  mulDivPkg::mulDivOp_u      op,
    input  logic [`MD_DATA_WIDTH-1:0] opA,
    input  logic [`MD_DATA_WIDTH-1:0] opB,
    input  logic [`MD_TAG_WIDTH-1:0]  tag,
    input  logic                      divRelease,
    input  logic                      flushValid,
    input  logic                      flushAll,
    input  logic [`MD_TAG_WIDTH-1:0]  flushHead,
    input  logic [`MD_TAG_WIDTH-1:0]  flushTail,
    output logic                      divFree,
    output logic                      divDone,
    output logic [`MD_DATA_WIDTH-1:0] divData,
    output logic [`MD_TAG_WIDTH-1:0]  divTag
);

    localparam int W = `MD_DATA_WIDTH;
    localparam int CNT_W = $clog2(W + 1);

    localparam logic [1:0] PHASE_FREE = 2'd0;
    localparam logic [1:0] PHASE_PROCESSING = 2'd1;
    localparam logic [1:0] PHASE_WAITING = 2'd2;

    logic [1:0]               phaseQ;
    logic [1:0]               nextPhase;
    logic [CNT_W-1:0]         countQ;
    logic                     lastStep;
    logic                     flushHit;
    logic                     accept;

    logic                     isSigned;
    logic                     negA;
    logic                     negB;
    logic [W-1:0]             magA;
    logic [W-1:0]             magB;

    mulDivPkg::divCode_e      codeQ;
    logic [`MD_TAG_WIDTH-1:0] tagQ;
    logic [W-1:0]             dividendQ;
    logic [W-1:0]             divisorQ;
    logic [W-1:0]             quoQ;
    logic [W:0]               remQ;
    logic                     qNegQ;
    logic                     rNegQ;
    logic                     zeroQ;
    logic                     overflowQ;
    logic [W-1:0]             resultQ;

    logic [W:0]               shifted;
    logic [W:0]               trial;
    logic [W-1:0]             quoFinal;
    logic [W-1:0]             remFinal;
    logic [W-1:0]             result;

    // W shift-subtract steps, then one cycle to fix up the result
    assign lastStep = countQ == CNT_W'(W);

    always_comb begin
        nextPhase = phaseQ;
        flushHit = flushValid && (phaseQ != PHASE_FREE) &&
            mulDivPkg::tagInFlushRange(flushAll, flushHead, flushTail, tagQ);
        case (phaseQ)
            PHASE_PROCESSING: begin
                if (lastStep) begin
                    nextPhase = PHASE_WAITING;
                end
            end
            PHASE_WAITING: begin
                if (divRelease) begin
                    nextPhase = PHASE_FREE;
                end
            end
            default: begin
                nextPhase = PHASE_FREE;
            end
        endcase
        if (flushHit) begin
            nextPhase = PHASE_FREE;
        end
        // Judged on the next phase so a flushed or released unit takes work at once
        divFree = nextPhase == PHASE_FREE;
        accept = divReq && divFree;
        if (accept) begin
            nextPhase = PHASE_PROCESSING;
        end
    end

    // Operand magnitudes and signs at issue
    always_comb begin
        isSigned = (op.div.code == mulDivPkg::DIV) || (op.div.code == mulDivPkg::REM);
        negA = isSigned && opA[W-1];
        negB = isSigned && opB[W-1];
        magA = negA ? -opA : opA;
        magB = negB ? -opB : opB;
    end

    always_comb begin
        shifted = {remQ[W-1:0], quoQ[W-1]};
        trial = shifted - {1'b0, divisorQ};
    end

    always_comb begin
        quoFinal = qNegQ ? -quoQ : quoQ;
        remFinal = rNegQ ? -remQ[W-1:0] : remQ[W-1:0];
        if (zeroQ) begin
            quoFinal = '1;
            remFinal = dividendQ;
        end else if (overflowQ) begin
            quoFinal = dividendQ;
            remFinal = '0;
        end
        if ((codeQ == mulDivPkg::REM) || (codeQ == mulDivPkg::REMU)) begin
            result = remFinal;
        end else begin
            result = quoFinal;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phaseQ <= PHASE_FREE;
            countQ <= '0;
        end else begin
            phaseQ <= nextPhase;
            if (accept) begin
                countQ <= '0;
            end else if ((phaseQ == PHASE_PROCESSING) && !lastStep) begin
                countQ <= countQ + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            codeQ <= op.div.code;
            tagQ <= tag;
            dividendQ <= opA;
            divisorQ <= magB;
            quoQ <= magA;
            remQ <= '0;
            qNegQ <= negA ^ negB;
            rNegQ <= negA;
            zeroQ <= opB == '0;
            overflowQ <= isSigned && (opA == {1'b1, {(W-1){1'b0}}}) && (opB == '1);
        end else if (phaseQ == PHASE_PROCESSING) begin
            if (lastStep) begin
                resultQ <= result;
            end else if (!trial[W]) begin
                // Divisor fits, keep the difference
                remQ <= trial;
                quoQ <= {quoQ[W-2:0], 1'b1};
            end else begin
                remQ <= shifted;
                quoQ <= {quoQ[W-2:0], 1'b0};
            end
        end
    end

    // A held result hit by a flush is withdrawn in the same cycle
    assign divDone = (phaseQ == PHASE_WAITING) && !flushHit;
    assign divData = resultQ;
    assign divTag = tagQ;

endmodule

/* verilog/resultMerger.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module resultMerger (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      mulOutValid,
    input  logic [`MD_DATA_WIDTH-1:0] mulOutData,
    input  logic [`MD_TAG_WIDTH-1:0]  mulOutTag,
    input  logic                      divDone,
    input  logic [`MD_DATA_WIDTH-1:0] divData,
    input  logic [`MD_TAG_WIDTH-1:0]  divTag,
    input  logic                      creditReturn,
    output logic                      mulTaken,
    output logic                      divRelease,
    output logic                      resultValid,
    output logic [`MD_DATA_WIDTH-1:0] resultData,
    output logic [`MD_TAG_WIDTH-1:0]  resultTag
);

    localparam int CW = $clog2(`MD_RESULT_CREDITS + 1);

    logic [CW-1:0] creditCount;
    logic          creditAvail;
    logic          takeDiv;
    logic          takeMul;

    // Counter drops when a result shows on the port, so the one
    // sitting in the output register still holds its credit here
    always_comb begin
        creditAvail = creditCount > CW'(resultValid);
        takeDiv = creditAvail && divDone;
        takeMul = creditAvail && mulOutValid && !divDone;
    end

    // Divider goes first since it blocks the next division while it waits
    assign divRelease = takeDiv;
    assign mulTaken = takeMul;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            creditCount <= CW'(`MD_RESULT_CREDITS);
        end else begin
            resultValid <= takeDiv || takeMul;
            case ({resultValid, creditReturn})
                2'b10: begin
                    creditCount <= creditCount - 1'b1;
                end
                2'b01: begin
                    creditCount <= creditCount + 1'b1;
                end
                default: begin
                    // Both or neither, count holds
                    creditCount <= creditCount;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (takeDiv) begin
            resultData <= divData;
            resultTag <= divTag;
        end else if (takeMul) begin
            resultData <= mulOutData;
            resultTag <= mulOutTag;
        end
    end

endmodule

/* verilog/mulDivUnit.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module mulDivUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      issueValid,
    input  logic                      isDiv,
    input  mulDivPkg::mulDivOp_u      op,
    input  logic [`MD_DATA_WIDTH-1:0] opA,
    input  logic [`MD_DATA_WIDTH-1:0] opB,
    input  logic [`MD_TAG_WIDTH-1:0]  tag,
    input  logic                      flushValid,
    input  logic                      flushAll,
    input  logic [`MD_TAG_WIDTH-1:0]  flushHead,
    input  logic [`MD_TAG_WIDTH-1:0]  flushTail,
    input  logic                      creditReturn,
    output logic                      issueReady,
    output logic                      resultValid,
    output logic [`MD_DATA_WIDTH-1:0] resultData,
    output logic [`MD_TAG_WIDTH-1:0]  resultTag
);

    logic                      mulValid;
    logic                      mulReady;
    logic                      mulTaken;
    logic                      mulOutValid;
    logic [`MD_DATA_WIDTH-1:0] mulOutData;
    logic [`MD_TAG_WIDTH-1:0]  mulOutTag;

    logic                      divReq;
    logic                      divFree;
    logic                      divRelease;
    logic                      divDone;
    logic [`MD_DATA_WIDTH-1:0] divData;
    logic [`MD_TAG_WIDTH-1:0]  divTag;

    // Steer the issue by isDiv, each unit checks its own readiness
    assign mulValid = issueValid && !isDiv;
    assign divReq = issueValid && isDiv;
    assign issueReady = isDiv ? divFree : mulReady;

    pipelinedMultiplier uMul (
        .clk         (clk),
        .arstN       (arstN),
        .mulValid    (mulValid),
        .op          (op),
        .opA         (opA),
        .opB         (opB),
        .tag         (tag),
        .mulTaken    (mulTaken),
        .flushValid  (flushValid),
        .flushAll    (flushAll),
        .flushHead   (flushHead),
        .flushTail   (flushTail),
        .mulReady    (mulReady),
        .mulOutValid (mulOutValid),
        .mulOutData  (mulOutData),
        .mulOutTag   (mulOutTag)
    );

    iterativeDivider uDiv (
        .clk        (clk),
        .arstN      (arstN),
        .divReq     (divReq),
        .op         (op),
        .opA        (opA),
        .opB        (opB),
        .tag        (tag),
        .divRelease (divRelease),
        .flushValid (flushValid),
        .flushAll   (flushAll),
        .flushHead  (flushHead),
        .flushTail  (flushTail),
        .divFree    (divFree),
        .divDone    (divDone),
        .divData    (divData),
        .divTag     (divTag)
    );

    resultMerger uMerge (
        .clk          (clk),
        .arstN        (arstN),
        .mulOutValid  (mulOutValid),
        .mulOutData   (mulOutData),
        .mulOutTag    (mulOutTag),
        .divDone      (divDone),
        .divData      (divData),
        .divTag       (divTag),
        .creditReturn (creditReturn),
        .mulTaken     (mulTaken),
        .divRelease   (divRelease),
        .resultValid  (resultValid),
        .resultData   (resultData),
        .resultTag    (resultTag)
    );

endmodule

/* verification/mulDiv_assertions.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module mulDivAssertions (
    input logic                                        clk,
    input logic                                        arstN,
    input logic                                        issueReady,
    input logic                                        resultValid,
    input logic                                        divRelease,
    input logic                                        divDone,
    input logic [$clog2(`MD_RESULT_CREDITS + 1)-1:0]   creditCount
);

    // A result on the port still holds its credit in the counter
    resultNeedsCredit: assert property (
        @(posedge clk) disable iff (!arstN)
        resultValid |-> (creditCount != '0)
    ) else $error("resultValid fired with the credit counter at zero");

    // First edge out of reset sees a quiet port and an open issue lane
    quietAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> !resultValid
    ) else $error("resultValid high on the first cycle after reset");

    readyAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> issueReady
    ) else $error("issueReady low on the first cycle after reset");

    // Merger may only release a divider that is holding a result
    releaseOnlyWhenDone: assert property (
        @(posedge clk) disable iff (!arstN)
        divRelease |-> divDone
    ) else $error("divRelease asserted while divDone was low");

endmodule

bind mulDivUnit mulDivAssertions uAssertions (
    .clk         (clk),
    .arstN       (arstN),
    .issueReady  (issueReady),
    .resultValid (resultValid),
    .divRelease  (divRelease),
    .divDone     (divDone),
    .creditCount (uMerge.creditCount)
);

/* verification/mulDivTb.sv */
`timescale 1ns/1ps
`include "mulDiv_macros.svh"

module mulDivTb;

    localparam int W = `MD_DATA_WIDTH;
    localparam int TW = `MD_TAG_WIDTH;
    localparam int NUM_ISSUES = 600;
    localparam logic [W-1:0] MIN_VALUE = {1'b1, {(W-1){1'b0}}};

    logic                 clk;
    logic                 arstN;
    logic                 issueValid;
    logic                 isDiv;
    mulDivPkg::mulDivOp_u op;
    logic [W-1:0]         opA;
    logic [W-1:0]         opB;
    logic [TW-1:0]        tag;
    logic                 flushValid;
    logic                 flushAll;
    logic [TW-1:0]        flushHead;
    logic [TW-1:0]        flushTail;
    logic                 creditReturn;
    logic                 issueReady;
    logic                 resultValid;
    logic [W-1:0]         resultData;
    logic [TW-1:0]        resultTag;

    // Expected result of every operation in flight, keyed by tag
    logic [W-1:0] expected [int];
    logic [W-1:0] pendingResult;
    int           creditDue [$];
    int           cycle;
    int           issued;
    int           resultsSeen;
    int           creditsReturned;
    bit           draining;
    bit           backPressureSeen;

    mulDivUnit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        repeat (NUM_ISSUES * (W + 10)) @(posedge clk);
        failRun($sformatf("Timeout: results still missing after %0d cycles", cycle));
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [W-1:0] actual,
                              input logic [W-1:0] wanted);
        if (actual !== wanted) begin
            failRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, wanted));
        end
    endtask

    // Edge values turn up often enough to hit every corner
    function automatic logic [W-1:0] pickOperand();
        case ($urandom_range(0, 7))
            0: return '0;
            1: return '1;
            2: return MIN_VALUE;
            3: return W'(1);
            default: return W'({$urandom, $urandom});
        endcase
    endfunction

    function automatic logic [W-1:0] expectedResult(input logic div, input mulDivPkg::mulDivOp_u o,
                                                    input logic [W-1:0] a, input logic [W-1:0] b);
        logic                aSigned;
        logic                bSigned;
        logic [2*W-1:0]      product;
        logic signed [W-1:0] sa;
        logic signed [W-1:0] sb;
        logic signed [W-1:0] quo;
        logic signed [W-1:0] rem;
        logic                overflow;
        if (!div) begin
            // Signed x unsigned means opA signed, opB unsigned
            aSigned = (o.mul.code == mulDivPkg::MUL_SS) || (o.mul.code == mulDivPkg::MUL_SU);
            bSigned = o.mul.code == mulDivPkg::MUL_SS;
            // Unsigned product, less 2^W times the other operand for each negative signed one
            product = {{W{1'b0}}, a} * {{W{1'b0}}, b};
            if (aSigned && a[W-1]) begin
                product = product - {b, {W{1'b0}}};
            end
            if (bSigned && b[W-1]) begin
                product = product - {a, {W{1'b0}}};
            end
            return o.mul.getUpper ? product[2*W-1:W] : product[W-1:0];
        end
        sa = a;
        sb = b;
        quo = sa / sb;
        rem = sa % sb;
        overflow = (a == MIN_VALUE) && (b == '1);
        case (o.div.code)
            mulDivPkg::DIV:  return (b == '0) ? '1 : (overflow ? a : quo);
            mulDivPkg::DIVU: return (b == '0) ? '1 : a / b;
            mulDivPkg::REM:  return (b == '0) ? a : (overflow ? '0 : rem);
            default:         return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic bit withholding();
        return !draining && (cycle % 400 >= 300);
    endfunction

    task automatic collectResult();
        if (resultValid) begin
            if (!expected.exists(resultTag)) begin
                failRun($sformatf("Result for tag %0d has no operation in flight", resultTag));
            end else begin
                checkValue($sformatf("resultData(tag %0d)", resultTag), resultData,
                    expected[resultTag]);
                expected.delete(resultTag);
            end
            resultsSeen++;
            checkValue("creditsInUse within limit",
                (resultsSeen - creditsReturned) <= `MD_RESULT_CREDITS, 1'b1);
            creditDue.push_back(cycle + $urandom_range(0, 5));
        end
    endtask

    task automatic driveInputs();
        int doomed [$];
        issueValid = 1'b0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        creditReturn = 1'b0;
        // Consumer hands back at most one credit per cycle
        for (int i = 0; i < creditDue.size() && !withholding(); i++) begin
            if (creditDue[i] <= cycle) begin
                creditDue.delete(i);
                creditReturn = 1'b1;
                creditsReturned++;
                break;
            end
        end
        if (draining) begin
            return;
        end
        if (!withholding() && $urandom_range(0, 99) < 3) begin
            flushValid = 1'b1;
            flushAll = $urandom_range(0, 3) == 0;
            flushHead = TW'($urandom);
            flushTail = TW'($urandom);
            foreach (expected[key]) begin
                if (flushAll || (TW'(key - flushHead) < TW'(flushTail - flushHead))) begin
                    doomed.push_back(key);
                end
            end
            foreach (doomed[i]) begin
                expected.delete(doomed[i]);
            end
        end else if (expected.num() < 8 && $urandom_range(0, 99) < 70) begin
            issueValid = 1'b1;
            isDiv = $urandom_range(0, 1);
            opA = pickOperand();
            opB = pickOperand();
            tag = TW'($urandom);
            while (expected.exists(tag)) begin
                tag = tag + 1'b1;
            end
            if (isDiv) begin
                op.div.code = mulDivPkg::divCode_e'(2'($urandom_range(0, 3)));
                op.div.spare = 1'b0;
                if ($urandom_range(0, 9) == 0) begin
                    opB = '0;
                end else if ($urandom_range(0, 9) == 0) begin
                    opA = MIN_VALUE;
                    opB = '1;
                end
            end else begin
                op.mul.code = mulDivPkg::mulCode_e'(2'($urandom_range(0, 2)));
                op.mul.getUpper = $urandom_range(0, 1);
            end
            pendingResult = expectedResult(isDiv, op, opA, opB);
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        draining = issued >= NUM_ISSUES;
        collectResult();
        driveInputs();
        @(posedge clk);
        if (issueValid && issueReady) begin
            expected[tag] = pendingResult;
            issued++;
        end else if (issueValid && !isDiv && withholding()) begin
            backPressureSeen = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'ha63e44b6));
        arstN = 1'b0;
        issueValid = 1'b0;
        isDiv = 1'b0;
        op = '0;
        opA = '0;
        opB = '0;
        tag = '0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        creditReturn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        while (issued < NUM_ISSUES || expected.num() != 0) begin
            stepCycle();
        end
        // Idle tail catches stray results and lets the last credits return
        repeat (20) stepCycle();
        checkValue("issueReady low under back-pressure", backPressureSeen, 1'b1);
        $display("Regression passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verilog
verilog/mulDivPkg.sv
verilog/pipelinedMultiplier.sv
verilog/iterativeDivider.sv
verilog/resultMerger.sv
verilog/mulDivUnit.sv
verification/mulDiv_assertions.sv
verification/mulDivTb.sv
